// ==== build.f ====
src/fibPkg.sv
src/aluUnit.sv
src/regFile.sv
src/recurrenceDatapath.sv
src/recurrenceSequencer.sv
src/fibTop.sv
sim/tb_fibTop.sv

// ==== Bender.yml ====
package:
  name: fib_recurrence

dependencies: {}

sources:
  # package first, then the datapath leaves, then the top level
  - files:
      - src/fibPkg.sv
      - src/aluUnit.sv
      - src/regFile.sv
      - src/recurrenceDatapath.sv
      - src/recurrenceSequencer.sv
      - src/fibTop.sv

  # self-checking testbench, top module tb_fibTop
  - target: simulation
    files:
      - sim/tb_fibTop.sv

  - target: test
    files:
      - sim/tb_fibTop.sv

// ==== sim/tb_fibTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fibTop;

	import fibPkg::*;

	localparam int runCount = 24;
	localparam int cyclesPerRun = 17 + 16 + 4;                     // run, readback, slack
	localparam int timeoutLimit = runCount * cyclesPerRun + 20;  // plus reset and first readback
	localparam logic [15:0] lfsrSeed = 16'd12545;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 start;
	logic [wordWidth-1:0] seedA;
	logic [wordWidth-1:0] seedB;
	aluOp_t               op;
	logic [addrWidth-1:0] readAddr;
	logic                 busy;
	logic                 done;
	commit_t              commit;
	logic [wordWidth-1:0] readData;

	logic [15:0]          lfsr = lfsrSeed;
	logic [wordWidth-1:0] model [regCount];  // expected register contents
	int                   cycleCount = 0;

	fibTop u_dut (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.seedA   (seedA),
		.seedB   (seedB),
		.op      (op),
		.readAddr(readAddr),
		.busy    (busy),
		.done    (done),
		.commit  (commit),
		.readData(readData)
	);

	always #50 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1, one shift per call
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	function automatic logic [15:0] randomBits(input int width);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < width; i++) begin
			lfsr = lfsrNext(lfsr);
			bits = {bits[14:0], lfsr[0]};  // one step for every bit taken
		end
		return bits;
	endfunction

	function automatic aluOp_t randomOp();
		logic [15:0] raw;
		raw = randomBits(2);
		while (raw[1:0] == 2'b11) begin
			raw = randomBits(2);  // the spare encoding is never a real run
		end
		return aluOp_t'(raw[1:0]);
	endfunction

	// r0 and r1 are the seeds, every later register combines the two before it
	task automatic buildModel(input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b,
			input aluOp_t runOp);
		model[0] = a;
		model[1] = b;
		for (int i = 2; i < regCount; i++) begin
			case (runOp)
				opAdd: model[i] = model[i-2] + model[i-1];
				opSub: model[i] = model[i-2] - model[i-1];
				default: model[i] = model[i-2] ^ model[i-1];
			endcase
		end
	endtask

	task automatic stopWithFailure();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkWord(input string name, input logic [wordWidth-1:0] expected,
			input logic [wordWidth-1:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkFlags(input logic expBusy, input logic expDone);
		if ({busy, done} !== {expBusy, expDone}) begin
			$display("error busy/done expected %h actual %h", {expBusy, expDone}, {busy, done});
			stopWithFailure();
		end
	endtask

	task automatic checkCommit(input commit_t expected, input commit_t actual);
		if (expected.valid && actual.valid !== 1'b1) begin
			$display("the commit for register %0d did not arrive at its edge", expected.addr);
			stopWithFailure();
		end else if (!expected.valid && actual.valid !== 1'b0) begin
			$display("a commit to register %0d appeared where none was due", actual.addr);
			stopWithFailure();
		end else if (expected.valid) begin
			if (actual.addr !== expected.addr) begin
				$display("error commit.addr expected %h actual %h", expected.addr, actual.addr);
				stopWithFailure();
			end else if (actual.data !== expected.data) begin
				$display("error commit.data expected %h actual %h", expected.data, actual.data);
				stopWithFailure();
			end
		end
	endtask

	// random start and seeds while busy, the sequencer must ignore them
	task automatic driveSpurious();
		logic [15:0] raw;
		raw = randomBits(1);
		start <= raw[0];
		seedA <= randomBits(16);
		seedB <= randomBits(16);
		raw = randomBits(2);
		op <= aluOp_t'(raw[1:0]);
	endtask

	// reads every register once, starting at a random address
	task automatic readbackAll(input logic expDone);
		logic [15:0]          raw;
		logic [addrWidth-1:0] addr;
		commit_t              idle;
		idle = '0;
		raw = randomBits(addrWidth);
		for (int i = 0; i < regCount; i++) begin
			addr = raw[addrWidth-1:0] + addrWidth'(i);
			@(posedge clk);
			readAddr <= addr;
			@(negedge clk);
			checkWord("readData", model[addr], readData);
			checkFlags(1'b0, expDone);
			checkCommit(idle, commit);
		end
	endtask

	task automatic runRecurrence(input aluOp_t runOp);
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		commit_t              expected;
		commit_t              idle;
		idle = '0;
		a = randomBits(16);
		b = randomBits(16);
		buildModel(a, b, runOp);
		@(posedge clk);
		start <= 1'b1;
		seedA <= a;
		seedB <= b;
		op <= runOp;
		@(posedge clk);  // the accepting edge samples the values above
		driveSpurious();
		for (int k = 0; k < regCount; k++) begin
			@(negedge clk);
			expected.valid = 1'b1;
			expected.addr = addrWidth'(k);
			expected.data = model[k];
			checkCommit(expected, commit);
			checkFlags(1'b1, 1'b0);  // also shows done fell after the accepting edge
			@(posedge clk);
			if (k < regCount - 1) begin
				driveSpurious();
			end else begin
				start <= 1'b0;  // busy is low after this edge
			end
		end
		@(negedge clk);
		checkFlags(1'b0, 1'b1);  // done exactly 16 edges after acceptance
		checkCommit(idle, commit);
		readbackAll(1'b1);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("the run hung and did not finish within %0d cycles", cycleCount);
			stopWithFailure();
		end
	end

	initial begin
		reset = 1'b0;
		start = 1'b0;
		seedA = '0;
		seedB = '0;
		op = opAdd;
		readAddr = '0;
		for (int i = 0; i < regCount; i++) begin
			model[i] = '0;  // cleared register file after reset
		end
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		readbackAll(1'b0);
		for (int run = 0; run < runCount; run++) begin
			case (run)
				0: runRecurrence(opAdd);
				1: runRecurrence(opSub);
				2: runRecurrence(opXor);
				default: runRecurrence(randomOp());
			endcase
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/fibTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module fibTop (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [fibPkg::wordWidth-1:0] seedA,
	input  logic [fibPkg::wordWidth-1:0] seedB,
	input  fibPkg::aluOp_t               op,
	input  logic [fibPkg::addrWidth-1:0] readAddr,
	output logic                         busy,
	output logic                         done,
	output fibPkg::commit_t              commit,
	output logic [fibPkg::wordWidth-1:0] readData
);

	import fibPkg::*;

	seqCtrl_t ctrl;  // one write request per cycle, no back-pressure

	recurrenceSequencer uSequencer (
		.clk  (clk),
		.reset(reset),
		.start(start),
		.seedA(seedA),
		.seedB(seedB),
		.op   (op),
		.ctrl (ctrl),
		.busy (busy),
		.done (done)
	);

	// the datapath commits whatever ctrl asks for in the same cycle
	recurrenceDatapath uDatapath (
		.clk     (clk),
		.reset   (reset),
		.ctrl    (ctrl),
		.readAddr(readAddr),
		.readData(readData),
		.commit  (commit)
	);

endmodule

`default_nettype wire

// ==== src/recurrenceSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module recurrenceSequencer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [fibPkg::wordWidth-1:0] seedA,
	input  logic [fibPkg::wordWidth-1:0] seedB,
	input  fibPkg::aluOp_t               op,
	output fibPkg::seqCtrl_t             ctrl,
	output logic                         busy,
	output logic                         done
);

	import fibPkg::*;

	logic                 running;     // a run is in progress
	logic                 doneFlag;    // last run completed and no new start yet
	logic [addrWidth-1:0] step;        // register written in the current cycle
	logic [wordWidth-1:0] seedALatch;  // value for r0
	logic [wordWidth-1:0] seedBLatch;  // value for r1
	aluOp_t               opLatch;     // operation used for the whole run
	logic                 accept;
	logic                 lastWrite;

	// start only counts while idle, a pulse during a run is dropped
	assign accept = start && !running;
	assign lastWrite = running && (step == addrWidth'(regCount - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			running <= 1'b0;
			doneFlag <= 1'b0;
			step <= '0;
		end else begin
			if (accept) begin
				running <= 1'b1;
				doneFlag <= 1'b0;   // done drops on the accepting edge
				step <= '0;
			end else if (lastWrite) begin
				running <= 1'b0;   // r15 is taken at this edge
				doneFlag <= 1'b1;
				step <= '0;
			end else if (running) begin
				step <= step + 1'b1;
			end
		end
	end

	// Seeds and op are sampled once, at the accepting edge, and then held for the run
	always_ff @(posedge clk) begin
		if (accept) begin
			seedALatch <= seedA;
			seedBLatch <= seedB;
			opLatch <= op;
		end
	end

	// counted sequencing replaces one state per register
	always_comb begin
		ctrl.writeEnable = running;
		ctrl.useImmediate = (step < addrWidth'(2));  // steps 0 and 1 write seeds
		ctrl.rdest = step;
		ctrl.rsrcA = step - addrWidth'(2);  // wraps during seed steps, unused there
		ctrl.rsrcB = step - addrWidth'(1);
		ctrl.immediate = (step == '0) ? seedALatch : seedBLatch;
		ctrl.op = opLatch;
	end

	assign busy = running;
	assign done = doneFlag;

endmodule

`default_nettype wire

// ==== src/recurrenceDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module recurrenceDatapath (
	input  logic                         clk,
	input  logic                         reset,
	input  fibPkg::seqCtrl_t             ctrl,
	input  logic [fibPkg::addrWidth-1:0] readAddr,
	output logic [fibPkg::wordWidth-1:0] readData,
	output fibPkg::commit_t              commit
);

	import fibPkg::*;

	logic [wordWidth-1:0] operandA;
	logic [wordWidth-1:0] operandB;
	logic [wordWidth-1:0] aluResult;
	logic [wordWidth-1:0] writeData;

	// operands come straight from the addresses the sequencer requests
	regFile uRegFile (
		.clk        (clk),
		.reset      (reset),
		.writeEnable(ctrl.writeEnable),
		.writeAddr  (ctrl.rdest),
		.writeData  (writeData),
		.readAddrA  (ctrl.rsrcA),
		.readAddrB  (ctrl.rsrcB),
		.readAddrExt(readAddr),
		.readDataA  (operandA),
		.readDataB  (operandB),
		.readDataExt(readData)
	);

	aluUnit uAlu (
		.a     (operandA),
		.b     (operandB),
		.op    (ctrl.op),
		.result(aluResult)
	);

	// seeds bypass the ALU, every later register takes the recurrence result
	assign writeData = ctrl.useImmediate ? ctrl.immediate : aluResult;

	// the commit record mirrors exactly what the register file takes at the next edge
	always_comb begin
		commit.valid = ctrl.writeEnable;
		commit.addr = ctrl.rdest;
		commit.data = writeData;
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         writeEnable,
	input  logic [fibPkg::addrWidth-1:0] writeAddr,
	input  logic [fibPkg::wordWidth-1:0] writeData,
	input  logic [fibPkg::addrWidth-1:0] readAddrA,
	input  logic [fibPkg::addrWidth-1:0] readAddrB,
	input  logic [fibPkg::addrWidth-1:0] readAddrExt,
	output logic [fibPkg::wordWidth-1:0] readDataA,
	output logic [fibPkg::wordWidth-1:0] readDataB,
	output logic [fibPkg::wordWidth-1:0] readDataExt
);

	import fibPkg::*;

	logic [wordWidth-1:0] regs [regCount];
	logic [regCount-1:0]  writeSel;

	// one-hot select of the register written this cycle, all zero when idle
	always_comb begin
		writeSel = '0;
		if (writeEnable) begin
			writeSel[writeAddr] = 1'b1;
		end
	end

	// the whole array clears on reset so readback starts from known zeros
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (writeSel[i]) begin
					regs[i] <= writeData;
				end
			end
		end
	end

	// Reads are combinational, so an operand written at the last edge is already visible
	assign readDataA = regs[readAddrA];    // r[i-2] for the ALU
	assign readDataB = regs[readAddrB];    // r[i-1] for the ALU
	assign readDataExt = regs[readAddrExt];  // environment readback port

endmodule

`default_nettype wire

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  logic [fibPkg::wordWidth-1:0] a,
	input  logic [fibPkg::wordWidth-1:0] b,
	input  fibPkg::aluOp_t               op,
	output logic [fibPkg::wordWidth-1:0] result
);

	import fibPkg::*;

	logic [wordWidth-1:0] sum;
	logic [wordWidth-1:0] difference;
	logic [wordWidth-1:0] exclusive;

	// all three are plain word-wide results, the carry out is simply dropped
	assign sum = a + b;
	assign difference = a - b;
	assign exclusive = a ^ b;

	// new operations only need a new enum value and a new case arm here
	always_comb begin
		case (op)
			opAdd: begin
				result = sum;
			end
			opSub: begin
				result = difference;
			end
			opXor: begin
				result = exclusive;
			end
			default: begin
				result = '0;  // the spare encoding yields zero
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/fibPkg.sv ====
`default_nettype none

package fibPkg;

	localparam int wordWidth = 16;                // every register and ALU word
	localparam int regCount = 16;                 // r0 and r1 hold seeds, r2..r15 are computed
	localparam int addrWidth = $clog2(regCount);  // 4 bits for sixteen registers

	// recurrence operations, the fourth encoding is unused
	typedef enum logic [1:0] {
		opAdd = 2'b00,
		opSub = 2'b01,
		opXor = 2'b10
	} aluOp_t;

	// one write request per cycle from the sequencer to the datapath
	typedef struct packed {
		logic                 writeEnable;   // a register write is requested this cycle
		logic                 useImmediate;  // write the immediate instead of the ALU result
		logic [addrWidth-1:0] rdest;         // register being written
		logic [addrWidth-1:0] rsrcA;         // operand r[i-2]
		logic [addrWidth-1:0] rsrcB;         // operand r[i-1]
		logic [wordWidth-1:0] immediate;     // seed value for the first two writes
		aluOp_t               op;            // operation applied to the two operands
	} seqCtrl_t;

	// the write that the register file takes at the next edge
	typedef struct packed {
		logic                 valid;  // high for exactly one cycle per write
		logic [addrWidth-1:0] addr;   // register written
		logic [wordWidth-1:0] data;   // value written
	} commit_t;

endpackage

`default_nettype wire
